/* all.f */
+incdir+.
soc_boundary_pkg.sv
reg_port_isolate.sv
reg_addr_demux.sv
reg_cdc_4phase_src.sv
soc_boundary_top.sv
tb_clock_gen.sv
tb_soc_boundary.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_boundary
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wall -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_soc_boundary.sv */
// Directed testbench for the register bus boundary.
// Models two same-domain slave memories and two far-domain four-phase
// responders, then runs sync, async, isolation and random mixed traffic
// against a reference memory keyed by slave index and offset.

`timescale 1ns/1ps
`include "soc_boundary_settings.svh"

module tb_soc_boundary
  import soc_boundary_pkg::*;
;

  localparam int unsigned timeout_cycles = 200;

  logic                          clk;
  logic                          rst_n;
  logic                          far_clk;
  logic                          isolate;
  logic                          isolated;
  logic                          req_valid;
  logic                          req_write;
  reg_addr_u                     req_addr;
  logic [`SB_DATA_W-1:0]         req_wdata;
  logic                          rsp_ready;
  logic [`SB_DATA_W-1:0]         rsp_rdata;
  logic                          rsp_error;
  logic [1:0]                    sync_req_valid;
  logic                          sync_req_write;
  reg_addr_u                     sync_req_addr;
  logic [`SB_DATA_W-1:0]         sync_req_wdata;
  logic [1:0]                    sync_rsp_ready;
  logic [1:0][`SB_DATA_W-1:0]    sync_rsp_rdata;
  logic [1:0]                    sync_rsp_error;
  logic [1:0]                    async_req_o;
  logic [1:0]                    async_ack_i;
  logic [1:0]                    async_write_o;
  reg_addr_u [1:0]               async_addr_o;
  logic [1:0][`SB_DATA_W-1:0]    async_wdata_o;
  logic [1:0]                    async_req_i;
  logic [1:0]                    async_ack_o;
  logic [1:0][`SB_DATA_W-1:0]    async_rdata_i;
  logic [1:0]                    async_error_i;

  // Slave models and reference state
  logic [`SB_DATA_W-1:0]         sync_mem [2][256];
  logic [`SB_DATA_W-1:0]         far_mem [2][256];
  logic [`SB_DATA_W-1:0]         ref_mem [4][256];
  int                            sync_hits [2];
  int                            far_reqs [2];
  logic [`SB_SLV_IDX_W-1:0]      last_port;
  reg_addr_u                     last_addr;
  logic [`SB_DATA_W-1:0]         last_wdata;
  reg_addr_u                     far_last_addr [2];
  logic [`SB_DATA_W-1:0]         far_last_wdata [2];
  logic [31:0]                   lfsr_state;
  logic                          busy_done;

  tb_clock_gen #(.period_ns(100), .reset_cycles(16)) i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  // Far domain runs on an unrelated period
  tb_clock_gen #(.period_ns(70), .reset_cycles(16)) i_far_clk_gen (
    .clk_o   ( far_clk ),
    .rst_n_o (         )
  );

  soc_boundary_top dut0 (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .isolate_i        ( isolate        ),
    .isolated_o       ( isolated       ),
    .req_valid_i      ( req_valid      ),
    .req_write_i      ( req_write      ),
    .req_addr_i       ( req_addr       ),
    .req_wdata_i      ( req_wdata      ),
    .rsp_ready_o      ( rsp_ready      ),
    .rsp_rdata_o      ( rsp_rdata      ),
    .rsp_error_o      ( rsp_error      ),
    .sync_req_valid_o ( sync_req_valid ),
    .sync_req_write_o ( sync_req_write ),
    .sync_req_addr_o  ( sync_req_addr  ),
    .sync_req_wdata_o ( sync_req_wdata ),
    .sync_rsp_ready_i ( sync_rsp_ready ),
    .sync_rsp_rdata_i ( sync_rsp_rdata ),
    .sync_rsp_error_i ( sync_rsp_error ),
    .async_req_o      ( async_req_o    ),
    .async_ack_i      ( async_ack_i    ),
    .async_write_o    ( async_write_o  ),
    .async_addr_o     ( async_addr_o   ),
    .async_wdata_o    ( async_wdata_o  ),
    .async_req_i      ( async_req_i    ),
    .async_ack_o      ( async_ack_o    ),
    .async_rdata_i    ( async_rdata_i  ),
    .async_error_i    ( async_error_i  )
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) lfsr_state = lfsr_state ^ 32'h8020_0003;
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  // Power-up content, a function of the whole address
  function automatic logic [`SB_DATA_W-1:0] fill_word(input logic [1:0] idx,
                                                      input logic [7:0] off);
    return {idx, 22'h0, off} ^ 32'h6b3d_91e5;
  endfunction

  function automatic reg_addr_u make_addr(input logic [1:0] idx, input logic [7:0] off);
    reg_addr_u a;
    a.fields.slv_idx = idx;
    a.fields.offset  = {22'h0, off};
    return a;
  endfunction

  task automatic fail_now(input string msg);
    $display("[FAIL] t=%0t %s", $time, msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input reg_addr_u got, input reg_addr_u exp, input string what);
    if (got !== exp) fail_now($sformatf("%s: addr %h, expected %h", what, got.raw, exp.raw));
  endtask

  task automatic check_data(input logic [`SB_DATA_W-1:0] got,
                            input logic [`SB_DATA_W-1:0] exp, input string what);
    if (got !== exp) fail_now($sformatf("%s: data %h, expected %h", what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) fail_now($sformatf("%s: flag %b, expected %b", what, got, exp));
  endtask

  task automatic check_port(input logic [`SB_SLV_IDX_W-1:0] got,
                            input logic [`SB_SLV_IDX_W-1:0] exp, input string what);
    if (got !== exp) fail_now($sformatf("%s: port %0d, expected %0d", what, got, exp));
  endtask

  // Same-domain slaves answer in the request cycle
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      sync_rsp_ready[k] = sync_req_valid[k];
      sync_rsp_rdata[k] = sync_mem[k][sync_req_addr.fields.offset[7:0]];
      sync_rsp_error[k] = 1'b0;
    end
  end

  always @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      if (sync_req_valid[k]) begin
        sync_hits[k] <= sync_hits[k] + 1;
        last_port    <= k[1:0];
        last_addr    <= sync_req_addr;
        last_wdata   <= sync_req_wdata;
        if (sync_req_write) sync_mem[k][sync_req_addr.fields.offset[7:0]] <= sync_req_wdata;
      end
    end
  end

  // Far-domain four-phase responder for crossing k
  task automatic far_responder(input int k);
    int                    cnt;
    logic                  wr;
    logic [7:0]            off;
    logic [`SB_DATA_W-1:0] rd;
    forever begin
      @(posedge far_clk);
      if (async_req_o[k]) begin
        wr  = async_write_o[k];
        off = async_addr_o[k].fields.offset[7:0];
        far_last_addr[k]  = async_addr_o[k];
        far_last_wdata[k] = async_wdata_o[k];
        far_reqs[k] = far_reqs[k] + 1;
        repeat (rand_bits(2)) @(posedge far_clk);
        async_ack_i[k] <= 1'b1;
        cnt = 0;
        while (async_req_o[k]) begin
          @(posedge far_clk);
          cnt++;
          if (cnt > timeout_cycles) timeout_fail("the crossing to drop its request");
        end
        async_ack_i[k] <= 1'b0;
        if (wr) far_mem[k][off] = far_last_wdata[k];
        rd = far_mem[k][off];
        repeat (rand_bits(2) + 1) @(posedge far_clk);
        async_rdata_i[k] <= rd;
        async_error_i[k] <= 1'b0;
        async_req_i[k]   <= 1'b1;
        cnt = 0;
        while (!async_ack_o[k]) begin
          @(posedge far_clk);
          cnt++;
          if (cnt > timeout_cycles) timeout_fail("the crossing to acknowledge the response");
        end
        async_req_i[k] <= 1'b0;
        cnt = 0;
        while (async_ack_o[k]) begin
          @(posedge far_clk);
          cnt++;
          if (cnt > timeout_cycles) timeout_fail("the crossing to drop its acknowledge");
        end
      end
    end
  endtask

  initial far_responder(0);
  initial far_responder(1);

  // One transfer on the SoC side, ready sampled at the falling edge
  task automatic bus_access(input logic wr, input reg_addr_u addr,
                            input logic [`SB_DATA_W-1:0] wd,
                            output logic [`SB_DATA_W-1:0] rd, output logic err);
    int cnt;
    @(posedge clk);
    req_valid <= 1'b1;
    req_write <= wr;
    req_addr  <= addr;
    req_wdata <= wd;
    cnt = 0;
    @(negedge clk);
    while (!rsp_ready) begin
      cnt++;
      if (cnt > timeout_cycles) timeout_fail("ready on the request port");
      @(negedge clk);
    end
    rd  = rsp_rdata;
    err = rsp_error;
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] idx, input logic [7:0] off,
                           input logic [`SB_DATA_W-1:0] data);
    logic [`SB_DATA_W-1:0] rd;
    logic                  err;
    bus_access(1'b1, make_addr(idx, off), data, rd, err);
    check_flag(err, 1'b0, "write error");
    ref_mem[idx][off] = data;
  endtask

  task automatic bus_read(input logic [1:0] idx, input logic [7:0] off);
    logic [`SB_DATA_W-1:0] rd;
    logic                  err;
    bus_access(1'b0, make_addr(idx, off), '0, rd, err);
    check_flag(err, 1'b0, "read error");
    check_data(rd, ref_mem[idx][off], $sformatf("read slave %0d offset %h", idx, off));
  endtask

  task automatic wait_isolated(input logic level);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (isolated !== level) begin
      cnt++;
      if (cnt > timeout_cycles) timeout_fail("isolated_o to change");
      @(negedge clk);
    end
  endtask

  task automatic test_sync_rw();
    int h0;
    int h1;
    for (int k = 0; k < 2; k++) begin
      // Slave model counters settle after the transfer edge
      @(negedge clk);
      h0 = sync_hits[0];
      h1 = sync_hits[1];
      bus_write(k[1:0], 8'h10 + k[7:0], 32'hc0de_0000 + k);
      @(negedge clk);
      check_port(last_port, k[1:0], "write port");
      check_addr(last_addr, make_addr(k[1:0], 8'h10 + k[7:0]), "sync write address");
      check_data(last_wdata, 32'hc0de_0000 + k, "sync write data");
      check_flag((sync_hits[0] - h0) == (k == 0) && (sync_hits[1] - h1) == (k == 1),
                 1'b1, "only the indexed port sees the write");
      bus_read(k[1:0], 8'h10 + k[7:0]);
    end
  endtask

  task automatic test_async_rw();
    int prev;
    for (int k = 0; k < 2; k++) begin
      prev = far_reqs[k];
      bus_write(k[1:0] + 2'd2, 8'h20 + k[7:0], 32'hfa5e_1000 + k);
      check_flag(far_reqs[k] == prev + 1, 1'b1, "one far request per write");
      check_addr(far_last_addr[k], make_addr(k[1:0] + 2'd2, 8'h20 + k[7:0]), "far address");
      check_data(far_last_wdata[k], 32'hfa5e_1000 + k, "far write data");
      bus_read(k[1:0] + 2'd2, 8'h20 + k[7:0]);
      check_flag(far_reqs[k] == prev + 2, 1'b1, "one far request per read");
    end
  endtask

  task automatic test_isolate_idle();
    logic [`SB_DATA_W-1:0] rd;
    logic                  err;
    int                    total;
    @(posedge clk);
    isolate <= 1'b1;
    wait_isolated(1'b1);
    total = sync_hits[0] + sync_hits[1] + far_reqs[0] + far_reqs[1];
    bus_access(1'b0, make_addr(2'd0, 8'h10), '0, rd, err);
    check_flag(err, 1'b1, "isolated read error");
    check_data(rd, '0, "isolated read data");
    bus_access(1'b1, make_addr(2'd2, 8'h30), 32'hdead_beef, rd, err);
    check_flag(err, 1'b1, "isolated write error");
    repeat (20) @(posedge clk);
    check_flag(total == sync_hits[0] + sync_hits[1] + far_reqs[0] + far_reqs[1], 1'b1,
               "no slave traffic while isolated");
    @(posedge clk);
    isolate <= 1'b0;
    wait_isolated(1'b0);
  endtask

  task automatic test_isolate_busy();
    int cnt;
    busy_done = 1'b0;
    fork
      begin
        bus_write(2'd3, 8'h44, 32'h1234_abcd);
        busy_done = 1'b1;
      end
      begin
        repeat (3) @(posedge clk);
        isolate <= 1'b1;
        cnt = 0;
        forever begin
          @(negedge clk);
          if (busy_done) break;
          check_flag(isolated, 1'b0, "isolated while the crossing is busy");
          cnt++;
          if (cnt > timeout_cycles) timeout_fail("the busy transfer to finish");
        end
      end
    join
    wait_isolated(1'b1);
  endtask

  task automatic test_release_random();
    logic [1:0]            idx;
    logic [7:0]            off;
    logic [`SB_DATA_W-1:0] data;
    @(posedge clk);
    isolate <= 1'b0;
    wait_isolated(1'b0);
    for (int n = 0; n < 40; n++) begin
      idx = rand_bits(2);
      off = rand_bits(4);
      if (rand_bits(1)) begin
        data = rand_bits(32);
        bus_write(idx, off, data);
      end else begin
        bus_read(idx, off);
      end
    end
  endtask

  initial begin
    int cnt;
    lfsr_state    = 32'd67;
    isolate       = 1'b0;
    req_valid     = 1'b0;
    req_write     = 1'b0;
    req_addr      = '0;
    req_wdata     = '0;
    async_ack_i   = '0;
    async_req_i   = '0;
    async_rdata_i = '0;
    async_error_i = '0;
    busy_done     = 1'b0;
    for (int k = 0; k < 2; k++) begin
      sync_hits[k] = 0;
      far_reqs[k]  = 0;
    end
    for (int i = 0; i < 256; i++) begin
      for (int k = 0; k < 2; k++) begin
        sync_mem[k][i] = fill_word(k[1:0], i[7:0]);
        far_mem[k][i]  = fill_word(k[1:0] + 2'd2, i[7:0]);
      end
      for (int k = 0; k < 4; k++) ref_mem[k][i] = fill_word(k[1:0], i[7:0]);
    end
    cnt = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cnt++;
      if (cnt > 100) timeout_fail("reset release");
    end
    check_flag(isolated, 1'b0, "isolated after reset");
    check_flag(|async_req_o, 1'b0, "crossing request after reset");
    test_sync_rw();
    test_async_rw();
    test_isolate_idle();
    test_isolate_busy();
    test_release_random();
    $display("TB PASSED");
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source.
// Makes a free running clock and holds an active low reset for a number of
// cycles. A second instance may give the far clock domain its own period.

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned period_ns    = 100,
  parameter int unsigned reset_cycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    forever #(period_ns / 2.0) clk_o = ~clk_o;
  end

  initial begin
    repeat (reset_cycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* soc_boundary_top.sv */
// Register bus boundary between the SoC master and the external slaves.
// Requests pass the isolation stage, then the address demux. Slaves 0 and 1
// are reached directly in this clock domain; slaves 2 and 3 each sit behind
// a four-phase crossing source.

`timescale 1ns/1ps
`include "soc_boundary_settings.svh"

module soc_boundary_top
  import soc_boundary_pkg::*;
#(
  localparam int unsigned NumSync  = `SB_NUM_SYNC_SLV,
  localparam int unsigned NumAsync = `SB_NUM_ASYNC_SLV,
  localparam int unsigned NumSlv   = NumSync + NumAsync
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                isolate_i,
  output logic                                isolated_o,
  // Request port from the SoC
  input  logic                                req_valid_i,
  input  logic                                req_write_i,
  input  reg_addr_u                           req_addr_i,
  input  logic [`SB_DATA_W-1:0]               req_wdata_i,
  output logic                                rsp_ready_o,
  output logic [`SB_DATA_W-1:0]               rsp_rdata_o,
  output logic                                rsp_error_o,
  // Same-domain slaves 0 and 1
  output logic [NumSync-1:0]                  sync_req_valid_o,
  output logic                                sync_req_write_o,
  output reg_addr_u                           sync_req_addr_o,
  output logic [`SB_DATA_W-1:0]               sync_req_wdata_o,
  input  logic [NumSync-1:0]                  sync_rsp_ready_i,
  input  logic [NumSync-1:0][`SB_DATA_W-1:0]  sync_rsp_rdata_i,
  input  logic [NumSync-1:0]                  sync_rsp_error_i,
  // Crossings to slaves 2 and 3
  output logic [NumAsync-1:0]                 async_req_o,
  input  logic [NumAsync-1:0]                 async_ack_i,
  output logic [NumAsync-1:0]                 async_write_o,
  output reg_addr_u [NumAsync-1:0]            async_addr_o,
  output logic [NumAsync-1:0][`SB_DATA_W-1:0] async_wdata_o,
  input  logic [NumAsync-1:0]                 async_req_i,
  output logic [NumAsync-1:0]                 async_ack_o,
  input  logic [NumAsync-1:0][`SB_DATA_W-1:0] async_rdata_i,
  input  logic [NumAsync-1:0]                 async_error_i
);

  logic                              iso_valid;
  logic                              iso_write;
  reg_addr_u                         iso_addr;
  logic [`SB_DATA_W-1:0]             iso_wdata;
  logic                              iso_ready;
  logic [`SB_DATA_W-1:0]             iso_rdata;
  logic                              iso_error;
  logic [NumSlv-1:0]                 slv_valid;
  logic                              slv_write;
  reg_addr_u                         slv_addr;
  logic [`SB_DATA_W-1:0]             slv_wdata;
  logic [NumSlv-1:0]                 slv_ready;
  logic [NumSlv-1:0][`SB_DATA_W-1:0] slv_rdata;
  logic [NumSlv-1:0]                 slv_error;

  reg_port_isolate i_isolate (
    .clk_i           ( clk_i       ),
    .rst_n_i         ( rst_n_i     ),
    .isolate_i       ( isolate_i   ),
    .isolated_o      ( isolated_o  ),
    .slv_req_valid_i ( req_valid_i ),
    .slv_req_write_i ( req_write_i ),
    .slv_req_addr_i  ( req_addr_i  ),
    .slv_req_wdata_i ( req_wdata_i ),
    .slv_rsp_ready_o ( rsp_ready_o ),
    .slv_rsp_rdata_o ( rsp_rdata_o ),
    .slv_rsp_error_o ( rsp_error_o ),
    .mst_req_valid_o ( iso_valid   ),
    .mst_req_write_o ( iso_write   ),
    .mst_req_addr_o  ( iso_addr    ),
    .mst_req_wdata_o ( iso_wdata   ),
    .mst_rsp_ready_i ( iso_ready   ),
    .mst_rsp_rdata_i ( iso_rdata   ),
    .mst_rsp_error_i ( iso_error   )
  );

  reg_addr_demux i_demux (
    .req_valid_i     ( iso_valid ),
    .req_write_i     ( iso_write ),
    .req_addr_i      ( iso_addr  ),
    .req_wdata_i     ( iso_wdata ),
    .rsp_ready_o     ( iso_ready ),
    .rsp_rdata_o     ( iso_rdata ),
    .rsp_error_o     ( iso_error ),
    .slv_req_valid_o ( slv_valid ),
    .slv_req_write_o ( slv_write ),
    .slv_req_addr_o  ( slv_addr  ),
    .slv_req_wdata_o ( slv_wdata ),
    .slv_rsp_ready_i ( slv_ready ),
    .slv_rsp_rdata_i ( slv_rdata ),
    .slv_rsp_error_i ( slv_error )
  );

  // Same-domain slaves take the low demux ports
  assign sync_req_valid_o        = slv_valid[NumSync-1:0];
  assign sync_req_write_o        = slv_write;
  assign sync_req_addr_o         = slv_addr;
  assign sync_req_wdata_o        = slv_wdata;
  assign slv_ready[NumSync-1:0]  = sync_rsp_ready_i;
  assign slv_rdata[NumSync-1:0]  = sync_rsp_rdata_i;
  assign slv_error[NumSync-1:0]  = sync_rsp_error_i;

  // Crossed slaves follow after the same-domain ones
  for (genvar i = 0; i < NumAsync; i++) begin : gen_async_slv
    reg_cdc_4phase_src i_cdc_src (
      .clk_i           ( clk_i                  ),
      .rst_n_i         ( rst_n_i                ),
      .src_req_valid_i ( slv_valid[NumSync + i] ),
      .src_req_write_i ( slv_write              ),
      .src_req_addr_i  ( slv_addr               ),
      .src_req_wdata_i ( slv_wdata              ),
      .src_rsp_ready_o ( slv_ready[NumSync + i] ),
      .src_rsp_rdata_o ( slv_rdata[NumSync + i] ),
      .src_rsp_error_o ( slv_error[NumSync + i] ),
      .async_req_o     ( async_req_o[i]         ),
      .async_ack_i     ( async_ack_i[i]         ),
      .async_write_o   ( async_write_o[i]       ),
      .async_addr_o    ( async_addr_o[i]        ),
      .async_wdata_o   ( async_wdata_o[i]       ),
      .async_req_i     ( async_req_i[i]         ),
      .async_ack_o     ( async_ack_o[i]         ),
      .async_rdata_i   ( async_rdata_i[i]       ),
      .async_error_i   ( async_error_i[i]       )
    );
  end

endmodule

/* reg_cdc_4phase_src.sv */
// Source side of a register bus crossing into another clock domain.
// One request is latched and sent with a four-phase req/ack pair, then the
// response comes back on a second four-phase pair. Ready pulses for one
// cycle once both handshakes have returned to zero. Req and ack inputs
// from the far side pass through synchronizers.

`timescale 1ns/1ps
`include "soc_boundary_settings.svh"

module reg_cdc_4phase_src
  import soc_boundary_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Register bus side
  input  logic                  src_req_valid_i,
  input  logic                  src_req_write_i,
  input  reg_addr_u             src_req_addr_i,
  input  logic [`SB_DATA_W-1:0] src_req_wdata_i,
  output logic                  src_rsp_ready_o,
  output logic [`SB_DATA_W-1:0] src_rsp_rdata_o,
  output logic                  src_rsp_error_o,
  // Forward handshake and request payload
  output logic                  async_req_o,
  input  logic                  async_ack_i,
  output logic                  async_write_o,
  output reg_addr_u             async_addr_o,
  output logic [`SB_DATA_W-1:0] async_wdata_o,
  // Return handshake and response payload
  input  logic                  async_req_i,
  output logic                  async_ack_o,
  input  logic [`SB_DATA_W-1:0] async_rdata_i,
  input  logic                  async_error_i
);

  localparam int unsigned sync_stages = `SB_CDC_SYNC_STAGES;

  localparam logic [2:0] s_idle     = 3'd0;
  localparam logic [2:0] s_send     = 3'd1;
  localparam logic [2:0] s_release  = 3'd2;
  localparam logic [2:0] s_wait_rsp = 3'd3;
  localparam logic [2:0] s_finish   = 3'd4;

  logic [2:0]             state_q;
  logic                   req_q;
  logic                   ack_q;
  logic                   ready_q;
  logic [sync_stages-1:0] ack_sync_q;
  logic [sync_stages-1:0] req_sync_q;
  logic                   ack_s;
  logic                   req_s;
  logic                   start;
  logic                   capture;
  logic                   write_q;
  reg_addr_u              addr_q;
  logic [`SB_DATA_W-1:0]  wdata_q;
  logic [`SB_DATA_W-1:0]  rdata_q;
  logic                   error_q;

  // Far-side levels into this clock
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_sync_q <= '0;
      req_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[sync_stages-2:0], async_ack_i};
      req_sync_q <= {req_sync_q[sync_stages-2:0], async_req_i};
    end
  end

  assign ack_s = ack_sync_q[sync_stages-1];
  assign req_s = req_sync_q[sync_stages-1];

  // No restart in the cycle that ready is still shown
  assign start   = (state_q == s_idle) & src_req_valid_i & ~ready_q;
  assign capture = (state_q == s_wait_rsp) & req_s;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= s_idle;
      req_q   <= 1'b0;
      ack_q   <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        s_idle: begin
          if (start) begin
            req_q   <= 1'b1;
            state_q <= s_send;
          end
        end
        s_send: begin
          if (ack_s) begin
            req_q   <= 1'b0;
            state_q <= s_release;
          end
        end
        // Far side must drop ack before the response phase
        s_release: begin
          if (!ack_s) begin
            state_q <= s_wait_rsp;
          end
        end
        s_wait_rsp: begin
          if (capture) begin
            ack_q   <= 1'b1;
            state_q <= s_finish;
          end
        end
        s_finish: begin
          if (!req_s) begin
            ack_q   <= 1'b0;
            ready_q <= 1'b1;
            state_q <= s_idle;
          end
        end
        default: state_q <= s_idle;
      endcase
    end
  end

  // Payload held stable across each handshake
  always_ff @(posedge clk_i) begin
    if (start) begin
      write_q <= src_req_write_i;
      addr_q  <= src_req_addr_i;
      wdata_q <= src_req_wdata_i;
    end
    if (capture) begin
      rdata_q <= async_rdata_i;
      error_q <= async_error_i;
    end
  end

  assign async_req_o     = req_q;
  assign async_write_o   = write_q;
  assign async_addr_o    = addr_q;
  assign async_wdata_o   = wdata_q;
  assign async_ack_o     = ack_q;
  assign src_rsp_ready_o = ready_q;
  assign src_rsp_rdata_o = rdata_q;
  assign src_rsp_error_o = error_q;

endmodule

/* reg_addr_demux.sv */
// Address demux from one register request port to the four slave ports.
// The slave index field of the address picks the target. Only that slave
// sees valid, the payload goes to all of them, and the response of the
// selected slave is returned. Purely combinational.

`timescale 1ns/1ps
`include "soc_boundary_settings.svh"

module reg_addr_demux
  import soc_boundary_pkg::*;
#(
  localparam int unsigned NumSlv = `SB_NUM_SYNC_SLV + `SB_NUM_ASYNC_SLV
) (
  // Request from the isolation stage
  input  logic                              req_valid_i,
  input  logic                              req_write_i,
  input  reg_addr_u                         req_addr_i,
  input  logic [`SB_DATA_W-1:0]             req_wdata_i,
  output logic                              rsp_ready_o,
  output logic [`SB_DATA_W-1:0]             rsp_rdata_o,
  output logic                              rsp_error_o,
  // Slave ports, payload shared
  output logic [NumSlv-1:0]                 slv_req_valid_o,
  output logic                              slv_req_write_o,
  output reg_addr_u                         slv_req_addr_o,
  output logic [`SB_DATA_W-1:0]             slv_req_wdata_o,
  input  logic [NumSlv-1:0]                 slv_rsp_ready_i,
  input  logic [NumSlv-1:0][`SB_DATA_W-1:0] slv_rsp_rdata_i,
  input  logic [NumSlv-1:0]                 slv_rsp_error_i
);

  logic [`SB_SLV_IDX_W-1:0] sel;

  // Index from the field view of the address
  assign sel = req_addr_i.fields.slv_idx;

  always_comb begin
    slv_req_valid_o      = '0;
    slv_req_valid_o[sel] = req_valid_i;
  end

  // Slaves get the full address word
  assign slv_req_write_o = req_write_i;
  assign slv_req_addr_o  = req_addr_i;
  assign slv_req_wdata_o = req_wdata_i;

  // Response back from the selected slave only
  assign rsp_ready_o = slv_rsp_ready_i[sel];
  assign rsp_rdata_o = slv_rsp_rdata_i[sel];
  assign rsp_error_o = slv_rsp_error_i[sel];

endmodule

/* reg_port_isolate.sv */
// Isolation stage on the register request port.
// With isolate_i low, requests and responses pass straight through.
// With isolate_i high, a request still in flight completes normally, then
// new requests are answered locally with an error and isolated_o is raised.

`timescale 1ns/1ps
`include "soc_boundary_settings.svh"

module reg_port_isolate
  import soc_boundary_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  isolate_i,
  output logic                  isolated_o,
  // Upstream side, from the bus master
  input  logic                  slv_req_valid_i,
  input  logic                  slv_req_write_i,
  input  reg_addr_u             slv_req_addr_i,
  input  logic [`SB_DATA_W-1:0] slv_req_wdata_i,
  output logic                  slv_rsp_ready_o,
  output logic [`SB_DATA_W-1:0] slv_rsp_rdata_o,
  output logic                  slv_rsp_error_o,
  // Downstream side, towards the demux
  output logic                  mst_req_valid_o,
  output logic                  mst_req_write_o,
  output reg_addr_u             mst_req_addr_o,
  output logic [`SB_DATA_W-1:0] mst_req_wdata_o,
  input  logic                  mst_rsp_ready_i,
  input  logic [`SB_DATA_W-1:0] mst_rsp_rdata_i,
  input  logic                  mst_rsp_error_i
);

  logic isolated_q;
  logic isolated_d;
  logic pending;
  logic fwd_en;

  // Path closes only once isolated_q is set, which waits for a quiet bus
  assign fwd_en = ~isolated_q;

  assign mst_req_valid_o = slv_req_valid_i & fwd_en;
  assign mst_req_write_o = slv_req_write_i;
  assign mst_req_addr_o  = slv_req_addr_i;
  assign mst_req_wdata_o = slv_req_wdata_i;

  always_comb begin
    if (fwd_en) begin
      slv_rsp_ready_o = mst_rsp_ready_i;
      slv_rsp_rdata_o = mst_rsp_rdata_i;
      slv_rsp_error_o = mst_rsp_error_i;
    end else begin
      // Local termination, same cycle as valid
      slv_rsp_ready_o = slv_req_valid_i;
      slv_rsp_rdata_o = '0;
      slv_rsp_error_o = 1'b1;
    end
  end

  // Forwarded but not accepted at this edge
  assign pending = mst_req_valid_o & ~mst_rsp_ready_i;

  // Isolation waits for the bus to go quiet, release is immediate
  assign isolated_d = isolate_i & ~pending;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      isolated_q <= 1'b0;
    end else begin
      isolated_q <= isolated_d;
    end
  end

  assign isolated_o = isolated_q;

endmodule

/* soc_boundary_pkg.sv */
// Types shared by the register boundary RTL and its testbench.
// One address word is read either raw or as a slave index with an offset.
// Modules take these by a wildcard import in their header.

`include "soc_boundary_settings.svh"

package soc_boundary_pkg;

  // Index in the top bits, offset inside the slave below it
  typedef struct packed {
    logic [`SB_SLV_IDX_W-1:0] slv_idx;
    logic [`SB_OFFSET_W-1:0]  offset;
  } reg_addr_fields_t;

  // Same word, two views
  typedef union packed {
    logic [`SB_ADDR_W-1:0] raw;
    reg_addr_fields_t      fields;
  } reg_addr_u;

endpackage

/* soc_boundary_settings.svh */
// Widths, slave counts and synchronizer depth for the register bus boundary.
// Include this header in any file that sizes a port or a register from it.
// The index and offset widths must add up to the address width.

`ifndef SOC_BOUNDARY_SETTINGS_SVH
`define SOC_BOUNDARY_SETTINGS_SVH

// Register bus address and data
`define SB_ADDR_W 32
`define SB_DATA_W 32

// Top address bits select the slave
`define SB_SLV_IDX_W 2
`define SB_OFFSET_W 30

// Slaves 0 and 1 share the bus clock
`define SB_NUM_SYNC_SLV 2

// Slaves 2 and 3 sit behind a four-phase crossing
`define SB_NUM_ASYNC_SLV 2

// Flops per synchronizer, at least two
`define SB_CDC_SYNC_STAGES 2

`endif
